//--- files.f
gf_pkg.sv
axil_pkg.sv
gf_mul_if.sv
gf_log_table.sv
gf_exp_table.sv
gf_mul_pipe.sv
gf_axil_regs.sv
gf_mul_top.sv
gf_mul_assert.sv
tb_gf_mul_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the GF(2^8) multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_gf_mul_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- tb_gf_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gf_mul_top
    import axil_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 67;
    localparam int HS_TIMEOUT = 100;              // cycles per handshake wait
    localparam int POLL_LIMIT = 20;               // RESULT reads before giving up
    localparam int N_RANDOM   = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   awvalid;
    logic                   awready;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [AXIL_DATA_W-1:0] wdata;
    logic                   bvalid;
    logic                   bready;
    axil_resp_e             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   rvalid;
    logic                   rready;
    logic [AXIL_DATA_W-1:0] rdata;
    axil_resp_e             rresp;

    int errors;
    int tests_run;
    int tests_failed;
    int hold_max;                                 // max cycles bready/rready stay low

    gf_mul_top gf_mul_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // next drive slot just after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("timeout, %s", why);
        $display("Simulation FAILED");
        $finish;
    endtask

    // bit-serial multiply reduced by 0x11D
    function automatic logic [7:0] ref_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ x;
            x = x[7] ? ((x << 1) ^ 8'h1D) : (x << 1);  // times x with x^8 folded back
        end
        return p;
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic stall_ready();
        int n;
        n = (hold_max > 0) ? int'($urandom_range(hold_max, 0)) : 0;
        repeat (n) step();                        // response held by the slave
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output axil_resp_e resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready)) begin        // both readies rise together
            n++;
            if (n > HS_TIMEOUT) abort_run("write address and data were never accepted");
            @(negedge clk);
        end
        step();                                   // aw and w taken at this edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        stall_ready();
        bready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > HS_TIMEOUT) abort_run("write response never arrived");
            @(negedge clk);
        end
        resp = bresp;
        step();
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output axil_resp_e resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > HS_TIMEOUT) abort_run("read address was never accepted");
            @(negedge clk);
        end
        step();
        arvalid = 1'b0;
        stall_ready();
        rready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > HS_TIMEOUT) abort_run("read data never arrived");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        step();
        rready = 1'b0;
    endtask

    // read RESULT until the done bit shows
    task automatic poll_result(output logic [31:0] data, output axil_resp_e resp);
        int polls;
        polls = 0;
        do begin
            axil_read(REG_RESULT, data, resp);
            polls++;
            if (!data[8] && polls >= POLL_LIMIT) abort_run("done flag never set");
        end while (!data[8]);
    endtask

    task automatic mul_check(input logic [7:0] a, input logic [7:0] b);
        axil_resp_e  resp;
        logic [31:0] data;
        axil_write(REG_OPERANDS, {16'h0, b, a}, resp);
        expect_equal("OPERANDS bresp", 32'(resp), 32'(RESP_OKAY));
        poll_result(data, resp);
        expect_equal("RESULT rresp", 32'(resp), 32'(RESP_OKAY));
        expect_equal($sformatf("%02h * %02h", a, b), data, {23'h0, 1'b1, ref_mul(a, b)});
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        axil_resp_e  resp;
        logic [31:0] data;
        logic [7:0]  x_val;
        logic [7:0]  a2;
        logic [7:0]  b2;
        int          mark;
        void'($urandom(SEED));
        rst_n        = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hold_max     = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        mark = errors;
        axil_read(REG_RESULT, data, resp);
        expect_equal("reset rresp", 32'(resp), 32'(RESP_OKAY));
        expect_equal("reset RESULT", data, 32'h0);
        finish_test("reset state", mark);

        mark = errors;
        repeat (N_RANDOM) mul_check(8'($urandom()), 8'($urandom()));
        finish_test("random products", mark);

        mark = errors;
        mul_check(8'h00, 8'h00);
        mul_check(8'h01, 8'h01);
        mul_check(8'h00, 8'h01);
        for (int i = 0; i < 8; i++) begin
            x_val = 8'($urandom());
            mul_check(8'h00, x_val);              // zero bypass
            mul_check(x_val, 8'h00);
            mul_check(8'h01, x_val);              // identity
            mul_check(x_val, 8'h01);
        end
        finish_test("zero and one operands", mark);

        mark = errors;
        mul_check(8'h8E, 8'h8E);                  // log sum past 255
        mul_check(8'hFF, 8'hFF);
        mul_check(8'h8E, 8'hFF);
        mul_check(8'hFF, 8'h8E);
        finish_test("large log sums", mark);

        mark = errors;
        mul_check(8'h53, 8'hCA);
        axil_write(4'h8, 32'h0000_0203, resp);
        expect_equal("write 0x8 bresp", 32'(resp), 32'(RESP_SLVERR));
        axil_write(REG_RESULT, 32'h0000_0405, resp);  // RESULT is read-only
        expect_equal("write RESULT bresp", 32'(resp), 32'(RESP_SLVERR));
        axil_read(4'h8, data, resp);
        expect_equal("read 0x8 rresp", 32'(resp), 32'(RESP_SLVERR));
        expect_equal("read 0x8 data", data, 32'h0);
        axil_read(REG_OPERANDS, data, resp);      // write-only register
        expect_equal("read OPERANDS rresp", 32'(resp), 32'(RESP_SLVERR));
        expect_equal("read OPERANDS data", data, 32'h0);
        axil_read(REG_RESULT, data, resp);
        expect_equal("RESULT after bad writes", data, {23'h0, 1'b1, ref_mul(8'h53, 8'hCA)});
        finish_test("unmapped access", mark);

        mark = errors;
        hold_max = 10;
        repeat (30) mul_check(8'($urandom()), 8'($urandom()));
        for (int k = 0; k < 6; k++) begin
            hold_max = (k % 2) * 10;              // tightest spacing on even k
            axil_write(REG_OPERANDS, 32'($urandom() & 32'hFFFF), resp);
            a2 = 8'($urandom());
            b2 = 8'($urandom());
            axil_write(REG_OPERANDS, {16'h0, b2, a2}, resp);
            poll_result(data, resp);
            expect_equal("back-to-back result", data, {23'h0, 1'b1, ref_mul(a2, b2)});
        end
        hold_max = 0;
        finish_test("back-pressure and back-to-back", mark);

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- gf_mul_assert.sv
`timescale 1ns/1ps
`default_nettype none

module gf_mul_assert
    import axil_pkg::*;
(
    input logic                   clk,
    input logic                   rst_n,
    input logic                   awvalid,
    input logic                   awready,
    input logic [AXIL_ADDR_W-1:0] awaddr,
    input logic                   bvalid,
    input logic                   bready,
    input axil_resp_e             bresp,
    input logic                   arvalid,
    input logic                   arready,
    input logic [AXIL_ADDR_W-1:0] araddr,
    input logic                   rvalid,
    input logic                   rready,
    input logic [AXIL_DATA_W-1:0] rdata
);

    logic       seen_wr;                          // an OPERANDS write happened
    logic [2:0] wr_age;                           // edges since it, saturates at 4

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_wr <= 1'b0;
            wr_age  <= '0;
        end else if (awvalid && awready && (awaddr == 4'h0)) begin
            seen_wr <= 1'b1;
            wr_age  <= '0;
        end else if (wr_age < 3'd4) begin
            wr_age <= wr_age + 3'd1;
        end
    end

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else $error("write response dropped or changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else $error("read data dropped or changed before rready");

    // done must be visible to a RESULT read taken 5+ edges after the write
    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && arready && (araddr == 4'h4) && seen_wr && (wr_age >= 3'd4))
        |=> (rvalid && rdata[8]))
        else $error("done flag not set 4 cycles after an OPERANDS write");

endmodule

bind gf_mul_top gf_mul_assert gf_mul_assert_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata)
);

`default_nettype wire

//--- gf_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

module gf_mul_top
    import axil_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [AXIL_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [AXIL_DATA_W-1:0] wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output axil_resp_e             bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [AXIL_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [AXIL_DATA_W-1:0] rdata,
    output axil_resp_e             rresp
);

    gf_mul_if gf_mul_if_i ();                     // regs to pipe

    // bus slave and register map
    gf_axil_regs gf_axil_regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .mul     (gf_mul_if_i.regs)
    );

    // log, add, antilog
    gf_mul_pipe gf_mul_pipe_i (
        .clk   (clk),
        .rst_n (rst_n),
        .mul   (gf_mul_if_i.pipe)
    );

endmodule

`default_nettype wire

//--- gf_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gf_axil_regs
    import axil_pkg::*;
    import gf_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [AXIL_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [AXIL_DATA_W-1:0] wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output axil_resp_e             bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [AXIL_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [AXIL_DATA_W-1:0] rdata,
    output axil_resp_e             rresp,
    gf_mul_if.regs                 mul
);

    typedef enum logic {W_IDLE, W_RESP} w_state_e;
    typedef enum logic {R_IDLE, R_DATA} r_state_e;

    w_state_e   w_state;
    r_state_e   r_state;
    logic       aw_hs;                            // aw and w taken together
    logic       ar_hs;
    logic       wr_ok;                            // write hits OPERANDS
    logic       rd_ok;                            // read hits RESULT
    gf_elem_t   result;                           // latest product
    logic       done;
    logic [1:0] in_flight;                        // products still in the pipe

    assign wr_ok   = (gf_reg_e'(awaddr) == REG_OPERANDS);
    assign rd_ok   = (gf_reg_e'(araddr) == REG_RESULT);
    assign awready = (w_state == W_IDLE) && awvalid && wvalid;
    assign wready  = awready;                     // same cycle accept
    assign aw_hs   = awready;
    assign bvalid  = (w_state == W_RESP);
    assign arready = (r_state == R_IDLE) && arvalid;  // low while rvalid
    assign ar_hs   = arready;
    assign rvalid  = (r_state == R_DATA);

    // write channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_state   <= W_IDLE;
            mul.start <= 1'b0;
        end else begin
            mul.start <= aw_hs && wr_ok;          // pulse with bvalid rise
            if (aw_hs) w_state <= W_RESP;
            else if (bready && (w_state == W_RESP)) w_state <= W_IDLE;
        end
    end

    // write payload held with bvalid
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            bresp     <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            mul.op_a  <= wdata[GF_M-1:0];         // strobes ignored
            mul.op_b  <= wdata[2*GF_M-1:GF_M];
        end
    end

    // read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_state <= R_IDLE;
        end else if (ar_hs) begin
            r_state <= R_DATA;
        end else if (rready && (r_state == R_DATA)) begin
            r_state <= R_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            rdata <= rd_ok ? {{(AXIL_DATA_W-GF_M-1){1'b0}}, done, result} : '0;
        end
    end

    // done marks only the product of the last start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result    <= '0;
            done      <= 1'b0;
            in_flight <= '0;
        end else begin
            if (mul.prod_valid) result <= mul.prod;  // always captured
            if (mul.start) done <= 1'b0;
            else if (mul.prod_valid && (in_flight == 2'd1)) done <= 1'b1;
            case ({mul.start, mul.prod_valid})
                2'b10:   in_flight <= in_flight + 2'd1;
                2'b01:   in_flight <= in_flight - 2'd1;
                default: in_flight <= in_flight;  // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

//--- gf_mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module gf_mul_pipe
    import gf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    gf_mul_if.pipe     mul
);

    gf_log_t    log_a;                            // stage 1 out, from rom
    gf_log_t    log_b;
    logic       zero_a1;                          // stage 1 zero flags
    logic       zero_b1;
    gf_logsum_t log_sum2;                         // stage 2, 9 bit sum
    logic       zero2;                            // either operand was 0
    logic       zero3;                            // aligned with exp rom output
    gf_elem_t   exp_val;                          // stage 3 out, from rom
    logic [2:0] vld;                              // valid beside the data

    // stage 1 log lookup
    gf_log_table gf_log_table_i (
        .clk   (clk),
        .a     (mul.op_a),
        .b     (mul.op_b),
        .log_a (log_a),
        .log_b (log_b)
    );

    // zero flags and log sum move with the rom reads
    always_ff @(posedge clk) begin
        zero_a1  <= (mul.op_a == '0);             // log of 0 is undefined
        zero_b1  <= (mul.op_b == '0);
        log_sum2 <= gf_logsum_t'(log_a) + gf_logsum_t'(log_b);  // keep the carry
        zero2    <= zero_a1 | zero_b1;
        zero3    <= zero2;
    end

    // stage 3 antilog lookup
    gf_exp_table gf_exp_table_i (
        .clk   (clk),
        .idx   (log_sum2),
        .value (exp_val)
    );

    // one valid bit per stage so three items can be in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[1:0], mul.start};
        end
    end

    assign mul.prod_valid = vld[2];
    assign mul.prod       = zero3 ? '0 : exp_val;  // zero bypass

endmodule

`default_nettype wire

//--- gf_exp_table.sv
`timescale 1ns/1ps
`default_nettype none

module gf_exp_table
    import gf_pkg::*;
(
    input  logic       clk,
    input  gf_logsum_t idx,                       // 0..508, raw sum of two logs
    output gf_elem_t   value
);

    gf_exp_tbl_t exp_rom;                         // 510 x 8, period repeated once

    // filled from gf_build_exp, upper half mirrors lower half
    initial begin
        exp_rom = gf_build_exp();
    end

    // registered read
    // the doubled table absorbs the wrap at 255 so the sum indexes directly
    always_ff @(posedge clk) begin
        value <= exp_rom[idx];                    // alpha^idx
    end

endmodule

`default_nettype wire

//--- gf_log_table.sv
`timescale 1ns/1ps
`default_nettype none

module gf_log_table
    import gf_pkg::*;
(
    input  logic     clk,
    input  gf_elem_t a,
    input  gf_elem_t b,
    output gf_log_t  log_a,
    output gf_log_t  log_b
);

    gf_log_tbl_t log_rom;                         // 256 x 8 rom

    // contents come from the polynomial at elaboration
    initial begin
        log_rom = gf_build_log();
    end

    // two read ports on the same rom
    always_ff @(posedge clk) begin
        log_a <= log_rom[a];                      // 1 cycle latency
        log_b <= log_rom[b];
    end

endmodule

`default_nettype wire

//--- gf_mul_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gf_mul_if
    import gf_pkg::*;
();

    logic     start;                              // one cycle per operand pair
    gf_elem_t op_a;
    gf_elem_t op_b;
    logic     prod_valid;                         // single cycle pulse
    gf_elem_t prod;

    // register block side
    modport regs (
        output start, op_a, op_b,
        input  prod_valid, prod
    );

    // multiplier side, always ready
    modport pipe (
        input  start, op_a, op_b,
        output prod_valid, prod
    );

endinterface

`default_nettype wire

//--- axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int AXIL_ADDR_W = 4;               // byte address, 16 byte window
    localparam int AXIL_DATA_W = 32;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2                        // unmapped or wrong direction
    } axil_resp_e;

    typedef enum logic [AXIL_ADDR_W-1:0] {
        REG_OPERANDS = 4'h0,                      // wo, b in 15:8, a in 7:0
        REG_RESULT   = 4'h4                       // ro, done in 8, product in 7:0
    } gf_reg_e;

endpackage

`default_nettype wire

//--- gf_pkg.sv
`default_nettype none

package gf_pkg;

    localparam int GF_M      = 8;                 // element width in bits
    localparam int GF_ORDER  = 255;               // multiplicative group size
    localparam int LOG_DEPTH = 256;               // one log entry per element
    localparam int EXP_DEPTH = 510;               // two periods of alpha^i
    localparam logic [GF_M:0] GF_POLY = 9'h11D;   // x^8+x^4+x^3+x^2+1

    typedef logic [GF_M-1:0] gf_elem_t;           // field element
    typedef logic [GF_M-1:0] gf_log_t;            // exponent of alpha, 0..254
    typedef logic [GF_M:0]   gf_logsum_t;         // sum of two logs, keeps carry

    typedef gf_elem_t gf_exp_tbl_t [EXP_DEPTH];   // antilog rom image
    typedef gf_log_t  gf_log_tbl_t [LOG_DEPTH];   // log rom image

    // multiply by the generator 2 and reduce
    function automatic gf_elem_t gf_mul_alpha(input gf_elem_t x);
        logic [GF_M:0] s;
        s = {x, 1'b0};                            // shift up one power
        if (s[GF_M]) s = s ^ GF_POLY;             // fold overflow back
        return s[GF_M-1:0];
    endfunction

    function automatic gf_exp_tbl_t gf_build_exp();
        gf_exp_tbl_t t;
        gf_elem_t    x;
        x = gf_elem_t'(1);                        // alpha^0
        for (int i = 0; i < EXP_DEPTH; i++) begin
            if (i < GF_ORDER) begin
                t[i] = x;
                x    = gf_mul_alpha(x);
            end else begin
                t[i] = t[i - GF_ORDER];           // second copy, no mod 255 later
            end
        end
        return t;
    endfunction

    function automatic gf_log_tbl_t gf_build_log();
        gf_log_tbl_t t;
        gf_elem_t    x;
        for (int i = 0; i < LOG_DEPTH; i++) t[i] = '0;  // log of 0 left at 0
        x = gf_elem_t'(1);
        for (int i = 0; i < GF_ORDER; i++) begin
            t[x] = gf_log_t'(i);                  // inverse of the exp walk
            x    = gf_mul_alpha(x);
        end
        return t;
    endfunction

endpackage

`default_nettype wire
